// File: logic/csr_pkg.sv
// Shared definitions for the machine-mode CSR file
// Widths, CSR addresses, reset and identity values, trap cause codes,
// access and trap structs, and the write/set/clear merge rule

package csr_pkg;

    // ------------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------------
    localparam int xlen       = 32;
    localparam int csr_addr_w = 12;
    localparam int cause_w    = 6;

    // ------------------------------------------------------------------
    // Architectural addresses
    // ------------------------------------------------------------------
    localparam logic [csr_addr_w-1:0] addr_mstatus       = 12'h300;
    localparam logic [csr_addr_w-1:0] addr_misa          = 12'h301;
    localparam logic [csr_addr_w-1:0] addr_medeleg       = 12'h302;
    localparam logic [csr_addr_w-1:0] addr_mideleg       = 12'h303;
    localparam logic [csr_addr_w-1:0] addr_mie           = 12'h304;
    localparam logic [csr_addr_w-1:0] addr_mtvec         = 12'h305;
    localparam logic [csr_addr_w-1:0] addr_mcountinhibit = 12'h320;
    localparam logic [csr_addr_w-1:0] addr_mscratch      = 12'h340;
    localparam logic [csr_addr_w-1:0] addr_mepc          = 12'h341;
    localparam logic [csr_addr_w-1:0] addr_mcause        = 12'h342;
    localparam logic [csr_addr_w-1:0] addr_mtval         = 12'h343;
    localparam logic [csr_addr_w-1:0] addr_mip           = 12'h344;
    localparam logic [csr_addr_w-1:0] addr_mvendorid     = 12'hF11;
    localparam logic [csr_addr_w-1:0] addr_marchid       = 12'hF12;
    localparam logic [csr_addr_w-1:0] addr_mimpid        = 12'hF13;
    localparam logic [csr_addr_w-1:0] addr_mhartid       = 12'hF14;

    typedef logic [xlen-1:0] csr_word_t;
    typedef logic [xlen-1:2] mtvec_base_t;      // Mode bits are fixed at zero

    localparam csr_word_t mtvec_reset     = 32'hC000_0000;
    localparam csr_word_t misa_value      = 32'h4000_0105; // MXL 1, ext bits 8, 2, 0
    localparam csr_word_t mvendorid_value = '0;
    localparam csr_word_t marchid_value   = '0;
    localparam csr_word_t mimpid_value    = '0;
    localparam csr_word_t mhartid_value   = '0;

    // MSTATUS bits that hold state
    localparam int mstatus_mie_bit  = 3;
    localparam int mstatus_mpie_bit = 7;

    // Cause codes accepted on a software write to MCAUSE
    localparam logic [cause_w-1:0] cause_ialign   = 6'd0;
    localparam logic [cause_w-1:0] cause_iaccess  = 6'd1;
    localparam logic [cause_w-1:0] cause_iopcode  = 6'd2;
    localparam logic [cause_w-1:0] cause_breakpt  = 6'd3;
    localparam logic [cause_w-1:0] cause_ldalign  = 6'd4;
    localparam logic [cause_w-1:0] cause_ldaccess = 6'd5;
    localparam logic [cause_w-1:0] cause_stalign  = 6'd6;
    localparam logic [cause_w-1:0] cause_staccess = 6'd7;
    localparam logic [cause_w-1:0] cause_ecallm   = 6'd11;

    // ------------------------------------------------------------------
    // Structs
    // ------------------------------------------------------------------
    typedef struct packed {
        logic                  en;      // Read enable
        logic                  wr;
        logic                  wr_set;
        logic                  wr_clr;
        logic [csr_addr_w-1:0] addr;
        csr_word_t             wdata;
    } csr_access_t;

    typedef struct packed {
        logic               cpu;        // Exception from the pipeline
        logic               intr;
        logic [cause_w-1:0] cause;
        csr_word_t          mtval;
        csr_word_t          pc;
    } trap_event_t;

    typedef struct packed {
        logic ir;
        logic tm;
        logic cy;
    } mcountinhibit_t;

    typedef struct packed {
        logic            mie;
        logic            mpie;
        csr_word_t       mepc;          // Bit 0 always zero
        logic            mcause_int;
        logic [xlen-2:0] mcause_code;
        csr_word_t       mtval;
    } trap_regs_t;

    // New value of a written word under set, else clear, else plain write
    function automatic csr_word_t csr_merge(csr_access_t acc, csr_word_t old_word);
        if (acc.wr_set) begin
            return old_word | acc.wdata;
        end else if (acc.wr_clr) begin
            return old_word & ~acc.wdata;
        end
        return acc.wdata;
    endfunction

endpackage

// File: logic/csr_field_reg.sv
// Single software-writable CSR field
// Decodes its own address, merges write/set/clear into a slice of the
// word and holds the result; generic over the field type

`timescale 1ns/1ps

module csr_field_reg #(
    parameter type                            field_t     = csr_pkg::csr_word_t,
    parameter logic [csr_pkg::csr_addr_w-1:0] field_addr  = '0,
    parameter int                             field_lsb   = 0,
    parameter field_t                         field_reset = '0
) (
    input  logic                 g_clk,
    input  logic                 g_resetn,
    input  csr_pkg::csr_access_t csr,
    output field_t               value
);

    import csr_pkg::*;

    localparam int field_w = $bits(field_t);

    logic      wen;
    csr_word_t old_word;    // Current value placed at its bit position
    csr_word_t new_word;

    assign wen = csr.wr && (csr.addr == field_addr);

    always_comb begin
        old_word = '0;
        old_word[field_lsb +: field_w] = value;
        new_word = csr_merge(csr, old_word);
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            value <= field_reset;
        end else if (wen) begin
            value <= field_t'(new_word[field_lsb +: field_w]);
        end
    end

endmodule

// File: logic/csr_trap_state.sv
// Trap-driven machine state
// MSTATUS.MIE/MPIE, MEPC, MCAUSE and MTVAL with trap capture, MRET
// restore, software access and the MCAUSE cause-code filter

`timescale 1ns/1ps

module csr_trap_state (
    input  logic                 g_clk,
    input  logic                 g_resetn,
    input  csr_pkg::csr_access_t csr,
    input  csr_pkg::trap_event_t trap,
    input  logic                 exec_mret,
    output csr_pkg::trap_regs_t  trap_regs,
    output csr_pkg::csr_word_t   mepc
);

    import csr_pkg::*;

    trap_regs_t regs_q;

    logic       any_trap;
    logic       wen_mstatus;
    logic       wen_mepc;
    logic       wen_mcause;
    logic       wen_mtval;
    logic       cause_ok;       // Raw write data is an implemented cause

    csr_word_t  mstatus_old;
    csr_word_t  mstatus_new;
    csr_word_t  mepc_new;
    csr_word_t  mcause_new;
    csr_word_t  mtval_new;

    // ------------------------------------------------------------------
    // Write decode
    // ------------------------------------------------------------------
    assign any_trap    = trap.intr || trap.cpu;
    assign wen_mstatus = csr.wr && (csr.addr == addr_mstatus);
    assign wen_mepc    = csr.wr && (csr.addr == addr_mepc);
    assign wen_mcause  = csr.wr && (csr.addr == addr_mcause);
    assign wen_mtval   = csr.wr && (csr.addr == addr_mtval);

    assign cause_ok = csr.wdata inside {
        xlen'(cause_ialign),  xlen'(cause_iaccess),  xlen'(cause_iopcode),
        xlen'(cause_breakpt), xlen'(cause_ldalign),  xlen'(cause_ldaccess),
        xlen'(cause_stalign), xlen'(cause_staccess), xlen'(cause_ecallm)
    };

    // Software merge of each register against its current word
    always_comb begin
        mstatus_old = '0;
        mstatus_old[mstatus_mie_bit]  = regs_q.mie;
        mstatus_old[mstatus_mpie_bit] = regs_q.mpie;
        mstatus_new = csr_merge(csr, mstatus_old);
        mepc_new    = csr_merge(csr, regs_q.mepc);
        mcause_new  = csr_merge(csr, {regs_q.mcause_int, regs_q.mcause_code});
        mtval_new   = csr_merge(csr, regs_q.mtval);
    end

    // ------------------------------------------------------------------
    // State update with interrupt above exception above MRET above software
    // ------------------------------------------------------------------
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            regs_q <= '0;
        end else if (any_trap) begin
            regs_q.mie         <= 1'b0;
            regs_q.mpie        <= regs_q.mie;
            regs_q.mepc        <= {trap.pc[xlen-1:1], 1'b0};
            regs_q.mcause_int  <= trap.intr;
            regs_q.mcause_code <= (xlen-1)'(trap.cause);
            if (!trap.intr) begin
                regs_q.mtval <= trap.mtval;         // Interrupts keep MTVAL
            end
        end else if (exec_mret) begin
            regs_q.mie  <= regs_q.mpie;
            regs_q.mpie <= 1'b0;
        end else begin
            if (wen_mstatus) begin
                regs_q.mie  <= mstatus_new[mstatus_mie_bit];
                regs_q.mpie <= mstatus_new[mstatus_mpie_bit];
            end
            if (wen_mepc) begin
                regs_q.mepc <= {mepc_new[xlen-1:1], 1'b0};
            end
            if (wen_mcause && cause_ok) begin
                regs_q.mcause_int  <= 1'b0;  // Software can only set exception causes
                regs_q.mcause_code <= mcause_new[xlen-2:0];
            end
            if (wen_mtval) begin
                regs_q.mtval <= mtval_new;
            end
        end
    end

    // ------------------------------------------------------------------
    // Outputs
    // ------------------------------------------------------------------
    assign trap_regs = regs_q;
    assign mepc      = regs_q.mepc;     // Return address to fetch

endmodule

// File: logic/csr_read_mux.sv
// CSR read port
// Builds every architectural register word from the held state and the
// constants, then selects one by address

`timescale 1ns/1ps

module csr_read_mux (
    input  csr_pkg::csr_access_t    csr,
    input  csr_pkg::trap_regs_t     trap_regs,
    input  csr_pkg::csr_word_t      mscratch,
    input  csr_pkg::mtvec_base_t    mtvec_base,
    input  csr_pkg::mcountinhibit_t mcountinhibit,
    output csr_pkg::csr_word_t      rdata
);

    import csr_pkg::*;

    csr_word_t mstatus_word;
    csr_word_t mtvec_word;
    csr_word_t mcountinhibit_word;
    csr_word_t mcause_word;

    // ------------------------------------------------------------------
    // Word assembly
    // ------------------------------------------------------------------
    always_comb begin
        mstatus_word = '0;      // Only MIE and MPIE are implemented
        mstatus_word[mstatus_mie_bit]  = trap_regs.mie;
        mstatus_word[mstatus_mpie_bit] = trap_regs.mpie;
    end

    assign mtvec_word         = {mtvec_base, 2'b00};   // Direct mode only
    assign mcountinhibit_word = xlen'(mcountinhibit);
    assign mcause_word        = {trap_regs.mcause_int, trap_regs.mcause_code};

    // ------------------------------------------------------------------
    // Address select
    // ------------------------------------------------------------------
    always_comb begin
        rdata = '0;
        if (csr.en) begin
            case (csr.addr)
                addr_mstatus:       rdata = mstatus_word;
                addr_misa:          rdata = misa_value;
                addr_medeleg:       rdata = '0;     // No delegation
                addr_mideleg:       rdata = '0;
                addr_mie:           rdata = '0;     // No interrupt sources wired
                addr_mip:           rdata = '0;
                addr_mtvec:         rdata = mtvec_word;
                addr_mcountinhibit: rdata = mcountinhibit_word;
                addr_mscratch:      rdata = mscratch;
                addr_mepc:          rdata = trap_regs.mepc;
                addr_mcause:        rdata = mcause_word;
                addr_mtval:         rdata = trap_regs.mtval;
                addr_mvendorid:     rdata = mvendorid_value;
                addr_marchid:       rdata = marchid_value;
                addr_mimpid:        rdata = mimpid_value;
                addr_mhartid:       rdata = mhartid_value;
                default:            rdata = '0;     // Unknown address
            endcase
        end
    end

endmodule

// File: logic/csr_file.sv
// Machine-mode CSR file top level
// Three software fields, the trap state and the read decoder

`timescale 1ns/1ps

module csr_file (
    input  logic                 g_clk,
    input  logic                 g_resetn,
    input  csr_pkg::csr_access_t csr,
    input  csr_pkg::trap_event_t trap,
    input  logic                 exec_mret,
    output csr_pkg::csr_word_t   csr_rdata,
    output csr_pkg::csr_word_t   csr_mepc,
    output csr_pkg::csr_word_t   csr_mtvec
);

    import csr_pkg::*;

    csr_word_t      mscratch;
    mtvec_base_t    mtvec_base;
    mcountinhibit_t mcountinhibit;
    trap_regs_t     trap_regs;

    // ------------------------------------------------------------------
    // Software fields
    // ------------------------------------------------------------------
    csr_field_reg #(
        .field_t     (csr_word_t),
        .field_addr  (addr_mscratch),
        .field_lsb   (0),
        .field_reset ('0)
    ) u_mscratch (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .csr      (csr),
        .value    (mscratch)
    );

    csr_field_reg #(
        .field_t     (mtvec_base_t),
        .field_addr  (addr_mtvec),
        .field_lsb   (2),
        .field_reset (mtvec_base_t'(mtvec_reset[xlen-1:2]))
    ) u_mtvec (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .csr      (csr),
        .value    (mtvec_base)
    );

    csr_field_reg #(
        .field_t     (mcountinhibit_t),
        .field_addr  (addr_mcountinhibit),
        .field_lsb   (0),
        .field_reset ('0)
    ) u_mcountinhibit (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .csr      (csr),
        .value    (mcountinhibit)
    );

    // ------------------------------------------------------------------
    // Trap state and read port
    // ------------------------------------------------------------------
    csr_trap_state u_trap_state (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .csr       (csr),
        .trap      (trap),
        .exec_mret (exec_mret),
        .trap_regs (trap_regs),
        .mepc      (csr_mepc)
    );

    csr_read_mux u_read_mux (
        .csr           (csr),
        .trap_regs     (trap_regs),
        .mscratch      (mscratch),
        .mtvec_base    (mtvec_base),
        .mcountinhibit (mcountinhibit),
        .rdata         (csr_rdata)
    );

    assign csr_mtvec = {mtvec_base, 2'b00};     // Trap vector to fetch

endmodule

// File: testbench/tb_csr_file.sv
// Testbench for the machine-mode CSR file
// Directed tests against a register model, clock, reset and result report

`timescale 1ns/1ps

module tb_csr_file;

    import csr_pkg::*;

    logic        g_clk;
    logic        g_resetn;
    csr_access_t csr;
    trap_event_t trap;
    logic        exec_mret;
    csr_word_t   csr_rdata;
    csr_word_t   csr_mepc;
    csr_word_t   csr_mtvec;

    // Register model
    csr_word_t   m_mscratch;
    csr_word_t   m_mtvec;
    csr_word_t   m_mcountinhibit;
    csr_word_t   m_mepc;
    csr_word_t   m_mcause;
    csr_word_t   m_mtval;
    logic        m_mie;
    logic        m_mpie;

    logic [31:0] lcg_state;
    string       test_name;
    int          test_errors;
    int          tests_run;
    int          tests_failed;
    int          reset_wait;

    csr_file u_dut (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .csr       (csr),
        .trap      (trap),
        .exec_mret (exec_mret),
        .csr_rdata (csr_rdata),
        .csr_mepc  (csr_mepc),
        .csr_mtvec (csr_mtvec)
    );

    always #2 g_clk = ~g_clk;

    // ------------------------------------------------------------------
    // Model helpers
    // ------------------------------------------------------------------
    function logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic csr_word_t merge_rule(csr_word_t old, csr_word_t data, logic set,
                                             logic clr);
        if (set) return old | data;
        if (clr) return old & ~data;
        return data;
    endfunction

    function automatic csr_word_t mstatus_model(logic mie, logic mpie);
        csr_word_t word;
        word    = '0;
        word[3] = mie;
        word[7] = mpie;
        return word;
    endfunction

    function automatic logic cause_accepted(csr_word_t data);
        return (data <= 32'd7) || (data == 32'd11);    // Codes 0 to 7 and ECALL
    endfunction

    // ------------------------------------------------------------------
    // Bus tasks
    // ------------------------------------------------------------------
    task automatic csr_write(input logic [11:0] addr, input csr_word_t data, input logic set,
                             input logic clr);
        csr_access_t acc;
        acc        = '0;
        acc.wr     = 1'b1;
        acc.wr_set = set;
        acc.wr_clr = clr;
        acc.addr   = addr;
        acc.wdata  = data;
        @(posedge g_clk);
        csr       <= acc;
        trap      <= '0;
        exec_mret <= 1'b0;
    endtask

    task automatic csr_read(input logic [11:0] addr, input logic en, output csr_word_t data);
        csr_access_t acc;
        acc      = '0;
        acc.en   = en;
        acc.addr = addr;
        @(posedge g_clk);
        csr       <= acc;
        trap      <= '0;
        exec_mret <= 1'b0;
        @(negedge g_clk);     // Read port settled
        data = csr_rdata;
    endtask

    task automatic trap_pulse(input trap_event_t ev);
        @(posedge g_clk);
        csr       <= '0;
        trap      <= ev;
        exec_mret <= 1'b0;
    endtask

    task automatic mret_pulse();
        @(posedge g_clk);
        csr       <= '0;
        trap      <= '0;
        exec_mret <= 1'b1;
    endtask

    // ------------------------------------------------------------------
    // Checking and reporting
    // ------------------------------------------------------------------
    task automatic check_word(input string what, input csr_word_t exp, input csr_word_t act);
        if (act !== exp) begin
            $display("Fail %s %s: expected %h, actual %h", test_name, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic read_check(input string what, input logic [11:0] addr, input csr_word_t exp);
        csr_word_t got;
        csr_read(addr, 1'b1, got);
        check_word(what, exp, got);
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
        tests_run++;
    endtask

    task automatic finish_test();
        if (test_errors == 0) begin
            $display("pass %s", test_name);
        end else begin
            $display("%s finished with %0d errors", test_name, test_errors);
            tests_failed++;
        end
    endtask

    // ------------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------------
    task automatic test_reset_constants();
        csr_word_t got;
        start_test("reset_constants");
        read_check("mtvec", addr_mtvec, 32'hC000_0000);
        check_word("csr_mtvec", 32'hC000_0000, csr_mtvec);
        read_check("mscratch", addr_mscratch, 32'h0);
        read_check("mstatus", addr_mstatus, 32'h0);
        read_check("mepc", addr_mepc, 32'h0);
        read_check("mcause", addr_mcause, 32'h0);
        read_check("mtval", addr_mtval, 32'h0);
        read_check("misa", addr_misa, 32'h4000_0105);
        read_check("mvendorid", addr_mvendorid, 32'h0);
        read_check("marchid", addr_marchid, 32'h0);
        read_check("mimpid", addr_mimpid, 32'h0);
        read_check("mhartid", addr_mhartid, 32'h0);
        read_check("unknown address", 12'hC00, 32'h0);
        csr_read(addr_misa, 1'b0, got);     // Enable low hides the word
        check_word("read with en low", 32'h0, got);
        finish_test();
    endtask

    task automatic test_mscratch();
        csr_word_t data;
        start_test("mscratch_access");
        for (int i = 0; i < 6; i++) begin
            data       = next_rand();
            m_mscratch = merge_rule(m_mscratch, data, (i % 3) == 1, (i % 3) == 2);
            csr_write(addr_mscratch, data, (i % 3) == 1, (i % 3) == 2);
            read_check("mscratch", addr_mscratch, m_mscratch);
        end
        finish_test();
    endtask

    task automatic test_field_slicing();
        csr_word_t data;
        start_test("field_slicing");
        data    = next_rand();
        m_mtvec = data & 32'hFFFF_FFFC;
        csr_write(addr_mtvec, data, 1'b0, 1'b0);
        read_check("mtvec", addr_mtvec, m_mtvec);
        check_word("csr_mtvec", m_mtvec, csr_mtvec);
        for (int op = 0; op < 3; op++) begin
            data            = next_rand();
            m_mcountinhibit = merge_rule(m_mcountinhibit, data, op == 1, op == 2) & 32'h7;
            csr_write(addr_mcountinhibit, data, op == 1, op == 2);
            read_check("mcountinhibit", addr_mcountinhibit, m_mcountinhibit);
        end
        finish_test();
    endtask

    task automatic test_cpu_trap();
        trap_event_t ev;
        logic [31:0] r;
        start_test("cpu_trap_mret");
        csr_write(addr_mstatus, 32'h0000_0008, 1'b0, 1'b0);
        m_mie  = 1'b1;
        m_mpie = 1'b0;
        read_check("mstatus before trap", addr_mstatus, mstatus_model(m_mie, m_mpie));
        r        = next_rand();
        ev       = '0;
        ev.cpu   = 1'b1;
        ev.cause = r[5:0];
        ev.pc    = next_rand();
        ev.mtval = next_rand();
        m_mpie   = m_mie;
        m_mie    = 1'b0;
        m_mepc   = ev.pc & 32'hFFFF_FFFE;
        m_mcause = 32'(ev.cause);
        m_mtval  = ev.mtval;
        trap_pulse(ev);
        read_check("mepc", addr_mepc, m_mepc);
        check_word("csr_mepc", m_mepc, csr_mepc);
        read_check("mcause", addr_mcause, m_mcause);
        read_check("mtval", addr_mtval, m_mtval);
        read_check("mstatus after trap", addr_mstatus, mstatus_model(m_mie, m_mpie));
        mret_pulse();
        m_mie  = m_mpie;
        m_mpie = 1'b0;
        read_check("mstatus after mret", addr_mstatus, mstatus_model(m_mie, m_mpie));
        finish_test();
    endtask

    task automatic test_interrupt_trap();
        trap_event_t ev;
        logic [31:0] r;
        start_test("interrupt_trap");
        r        = next_rand();
        ev       = '0;
        ev.intr  = 1'b1;
        ev.cause = r[5:0];
        ev.pc    = next_rand();
        ev.mtval = next_rand();     // Must not reach MTVAL
        m_mpie   = m_mie;
        m_mie    = 1'b0;
        m_mepc   = ev.pc & 32'hFFFF_FFFE;
        m_mcause = 32'h8000_0000 | 32'(ev.cause);
        trap_pulse(ev);
        read_check("mcause", addr_mcause, m_mcause);
        read_check("mepc", addr_mepc, m_mepc);
        check_word("csr_mepc", m_mepc, csr_mepc);
        read_check("mtval", addr_mtval, m_mtval);
        read_check("mstatus", addr_mstatus, mstatus_model(m_mie, m_mpie));
        finish_test();
    endtask

    task automatic test_mcause_filter();
        csr_word_t data;
        start_test("mcause_filter");
        data = 32'd11;
        if (cause_accepted(data)) m_mcause = data;
        csr_write(addr_mcause, data, 1'b0, 1'b0);
        read_check("mcause after 11", addr_mcause, m_mcause);
        data = 32'd9;
        if (cause_accepted(data)) m_mcause = data;
        csr_write(addr_mcause, data, 1'b0, 1'b0);
        read_check("mcause after 9", addr_mcause, m_mcause);
        finish_test();
    endtask

    // ------------------------------------------------------------------
    // Reset, sequencing and watchdog
    // ------------------------------------------------------------------
    initial begin
        repeat (16) @(posedge g_clk);
        g_resetn <= 1'b1;
    end

    initial begin
        #200000;
        $display("Simulation timed out");
        $display("Verification failed");
        $finish;
    end

    initial begin
        g_clk           = 1'b0;
        g_resetn        = 1'b0;
        csr             = '0;
        trap            = '0;
        exec_mret       = 1'b0;
        lcg_state       = 32'h8ef1_637f;
        tests_run       = 0;
        tests_failed    = 0;
        m_mscratch      = '0;
        m_mtvec         = 32'hC000_0000;
        m_mcountinhibit = '0;
        m_mepc          = '0;
        m_mcause        = '0;
        m_mtval         = '0;
        m_mie           = 1'b0;
        m_mpie          = 1'b0;
        reset_wait      = 0;
        while (!g_resetn && reset_wait < 100) begin
            @(posedge g_clk);
            reset_wait++;
        end
        if (!g_resetn) begin
            $display("Reset was never released");
            $display("Verification failed");
            $finish;
        end else begin
            test_reset_constants();
            test_mscratch();
            test_field_slicing();
            test_cpu_trap();
            test_interrupt_trap();
            test_mcause_filter();
            $display("Tests run %0d, passed %0d, failed %0d",
                     tests_run, tests_run - tests_failed, tests_failed);
            if (tests_failed == 0) begin
                $display("Verification passed");
            end else begin
                $display("Verification failed");
            end
            $finish;
        end
    end

endmodule

// File: src.f
logic/csr_pkg.sv
logic/csr_field_reg.sv
logic/csr_trap_state.sv
logic/csr_read_mux.sv
logic/csr_file.sv
testbench/tb_csr_file.sv

// File: run.sh
#!/bin/sh
# Build the CSR file testbench with Verilator, run it and scan the log
set -e

cd "$(dirname "$0")"

rm -f sim.log

verilator --binary --timing \
    --top-module tb_csr_file \
    --Mdir obj_dir \
    -f src.f

./obj_dir/Vtb_csr_file > sim.log 2>&1 || true
cat sim.log

if grep -q "Verification failed" sim.log; then
    exit 1
fi
exit 0
